// File: source/mlp_link_macros.svh
`ifndef MLP_LINK_MACROS_SVH
`define MLP_LINK_MACROS_SVH

// Clock cycles per serial bit
// The top-level parameter of the same purpose can be set from the build
`define MLP_CLKS_PER_BIT 16

// Payload bytes after a write opcode
`define MLP_PAYLOAD_BYTES 4

// Reply lengths in bytes
`define MLP_RESULT_BYTES 4
`define MLP_STATUS_BYTES 1

// MLP state code for idle
`define MLP_STATE_IDLE 4'd0

`endif

// File: source/mlp_link_pkg.sv
`default_nettype none

package mlp_link_pkg;

    typedef logic [7:0] byte_t;

    typedef enum logic [7:0] {
        CMD_WRITE_WEIGHT = 8'h01,
        CMD_WRITE_ACT    = 8'h02,
        CMD_EXECUTE      = 8'h03,
        CMD_READ_RESULT  = 8'h04,
        CMD_STATUS       = 8'h05
    } cmd_opcode_t;

    // Byte 0 of the payload sits in the low bits
    typedef logic [31:0]        payload_t;
    typedef logic [15:0]        act_row_t;
    typedef logic [3:0]         mlp_state_t;
    typedef logic [4:0]         cycle_cnt_t;
    typedef logic signed [31:0] acc_t;
    typedef logic [2:0]         resp_len_t;

endpackage

`default_nettype wire

// File: source/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlp_link_macros.svh"

module uart_rx import mlp_link_pkg::*; #(
    parameter int CLKS_PER_BIT = `MLP_CLKS_PER_BIT
) (
    input  wire   clk,
    input  wire   rst,
    input  wire   rxd,
    output byte_t rx_data,
    output logic  rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state;
    logic [2:0]       rxd_sync;
    logic [CNT_W-1:0] cyc_cnt;
    logic [2:0]       bit_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            rxd_sync <= '1;
            cyc_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            // Two synchronizer stages plus one for edge detection
            rxd_sync <= {rxd_sync[1:0], rxd};
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cyc_cnt <= '0;
                    if (rxd_sync[2] && !rxd_sync[1]) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (cyc_cnt == HALF_BIT) begin
                        cyc_cnt <= '0;
                        bit_idx <= '0;
                        // A glitch shorter than half a bit is not a start bit
                        state   <= rxd_sync[1] ? RX_IDLE : RX_DATA;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cyc_cnt == BIT_END) begin
                        cyc_cnt <= '0;
                        rx_data <= {rxd_sync[1], rx_data[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (cyc_cnt == BIT_END) begin
                        // Framing check on the stop bit
                        rx_valid <= rxd_sync[1];
                        state    <= RX_IDLE;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlp_link_macros.svh"

module uart_tx import mlp_link_pkg::*; #(
    parameter int CLKS_PER_BIT = `MLP_CLKS_PER_BIT
) (
    input  wire   clk,
    input  wire   rst,
    input  byte_t tx_data,
    input  wire   tx_valid,
    output logic  tx_ready,
    output logic  txd
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);

    logic             busy;
    logic [8:0]       frame;
    logic [3:0]       bit_cnt;
    logic [CNT_W-1:0] cyc_cnt;

    assign tx_ready = !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            txd     <= 1'b1;
            bit_cnt <= '0;
            cyc_cnt <= '0;
        end else if (!busy) begin
            if (tx_valid) begin
                // Stop bit above the data, data LSB first
                frame   <= {1'b1, tx_data};
                txd     <= 1'b0;
                busy    <= 1'b1;
                bit_cnt <= '0;
                cyc_cnt <= '0;
            end
        end else if (cyc_cnt == BIT_END) begin
            cyc_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                txd     <= frame[0];
                frame   <= {1'b1, frame[8:1]};
            end
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlp_link_macros.svh"

module cmd_parser import mlp_link_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  byte_t      rx_data,
    input  wire        rx_valid,
    input  mlp_state_t mlp_state,
    input  cycle_cnt_t mlp_cycle_cnt,
    input  acc_t       mlp_acc0,
    input  wire        resp_busy,
    output logic       load_weights,
    output logic       load_acts,
    output logic       exec_req,
    output payload_t   payload,
    output logic       resp_start,
    output payload_t   resp_word,
    output resp_len_t  resp_len
);

    typedef enum logic [1:0] {P_WAIT_OP, P_COLLECT, P_DISPATCH, P_REPLY} parse_state_t;

    parse_state_t state;
    cmd_opcode_t  op_q;
    logic [2:0]   pay_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= P_WAIT_OP;
            pay_cnt      <= '0;
            load_weights <= 1'b0;
            load_acts    <= 1'b0;
            exec_req     <= 1'b0;
            resp_start   <= 1'b0;
        end else begin
            load_weights <= 1'b0;
            load_acts    <= 1'b0;
            exec_req     <= 1'b0;
            resp_start   <= 1'b0;
            case (state)
                P_WAIT_OP: begin
                    pay_cnt <= '0;
                    if (rx_valid) begin
                        op_q <= cmd_opcode_t'(rx_data);
                        case (cmd_opcode_t'(rx_data))
                            CMD_WRITE_WEIGHT, CMD_WRITE_ACT: state <= P_COLLECT;
                            CMD_EXECUTE, CMD_READ_RESULT, CMD_STATUS: state <= P_DISPATCH;
                            // Unknown opcode is dropped
                            default: state <= P_WAIT_OP;
                        endcase
                    end
                end
                P_COLLECT: begin
                    if (rx_valid) begin
                        payload <= {rx_data, payload[31:8]};
                        pay_cnt <= pay_cnt + 1'b1;
                        if (pay_cnt == 3'(`MLP_PAYLOAD_BYTES - 1)) begin
                            state <= P_DISPATCH;
                        end
                    end
                end
                P_DISPATCH: begin
                    state <= P_WAIT_OP;
                    case (op_q)
                        CMD_WRITE_WEIGHT: load_weights <= 1'b1;
                        CMD_WRITE_ACT:    load_acts    <= 1'b1;
                        CMD_EXECUTE:      exec_req     <= 1'b1;
                        CMD_STATUS: begin
                            // State nibble above the low cycle-count nibble
                            resp_word  <= {24'd0, mlp_state, mlp_cycle_cnt[3:0]};
                            resp_len   <= resp_len_t'(`MLP_STATUS_BYTES);
                            resp_start <= 1'b1;
                            state      <= P_REPLY;
                        end
                        CMD_READ_RESULT: begin
                            resp_word  <= payload_t'(mlp_acc0);
                            resp_len   <= resp_len_t'(`MLP_RESULT_BYTES);
                            resp_start <= 1'b1;
                            state      <= P_REPLY;
                        end
                        default: state <= P_WAIT_OP;
                    endcase
                end
                P_REPLY: begin
                    // Busy rises one cycle after the start pulse
                    if (!resp_start && !resp_busy) begin
                        state <= P_WAIT_OP;
                    end
                end
                default: state <= P_WAIT_OP;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/mlp_loader.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlp_link_macros.svh"

module mlp_loader import mlp_link_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        load_weights,
    input  wire        load_acts,
    input  wire        exec_req,
    input  payload_t   payload,
    input  mlp_state_t mlp_state,
    output logic       wf_reset,
    output logic       wf_push_col0,
    output logic       wf_push_col1,
    output byte_t      wf_data_in,
    output logic       init_act_valid,
    output act_row_t   init_act_data,
    output logic       start_mlp,
    output logic       weights_ready
);

    payload_t   pay_q;
    logic [2:0] step;
    logic       seq_wt;
    mlp_state_t state_prev;
    logic [1:0] byte_idx;

    // Steps 1 to 4 carry payload bytes 0 to 3
    assign byte_idx = step[1:0] - 2'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            step           <= '0;
            seq_wt         <= 1'b0;
            wf_reset       <= 1'b0;
            wf_push_col0   <= 1'b0;
            wf_push_col1   <= 1'b0;
            init_act_valid <= 1'b0;
            start_mlp      <= 1'b0;
            weights_ready  <= 1'b0;
            state_prev     <= `MLP_STATE_IDLE;
        end else begin
            wf_reset       <= 1'b0;
            wf_push_col0   <= 1'b0;
            wf_push_col1   <= 1'b0;
            init_act_valid <= 1'b0;
            state_prev     <= mlp_state;
            if (load_weights) begin
                pay_q    <= payload;
                seq_wt   <= 1'b1;
                step     <= 3'd1;
                wf_reset <= 1'b1;
            end else if (load_acts) begin
                pay_q          <= payload;
                seq_wt         <= 1'b0;
                step           <= 3'd1;
                init_act_valid <= 1'b1;
                init_act_data  <= payload[15:0];
            end else if (step != 3'd0) begin
                if (seq_wt) begin
                    // Odd steps go to column 0, even steps to column 1
                    wf_data_in   <= pay_q[{byte_idx, 3'b000} +: 8];
                    wf_push_col0 <= step[0];
                    wf_push_col1 <= !step[0];
                    if (step == 3'd4) begin
                        weights_ready <= 1'b1;
                        step          <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end else begin
                    init_act_valid <= 1'b1;
                    init_act_data  <= pay_q[31:16];
                    step           <= '0;
                end
            end
            if (exec_req) begin
                start_mlp <= 1'b1;
            end else if (start_mlp && state_prev == `MLP_STATE_IDLE
                         && mlp_state != `MLP_STATE_IDLE) begin
                // MLP has taken the start and consumed the weights
                start_mlp     <= 1'b0;
                weights_ready <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/resp_sender.sv
`timescale 1ns/1ps
`default_nettype none

module resp_sender import mlp_link_pkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire       resp_start,
    input  payload_t  resp_word,
    input  resp_len_t resp_len,
    input  wire       tx_ready,
    output logic      resp_busy,
    output byte_t     tx_data,
    output logic      tx_valid
);

    payload_t  word_q;
    resp_len_t len_q;
    resp_len_t byte_idx;
    logic      sent;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_busy <= 1'b0;
            tx_valid  <= 1'b0;
            byte_idx  <= '0;
            sent      <= 1'b0;
        end else if (resp_start) begin
            word_q    <= resp_word;
            len_q     <= resp_len;
            byte_idx  <= '0;
            sent      <= 1'b0;
            resp_busy <= 1'b1;
        end else if (resp_busy) begin
            if (tx_valid) begin
                // Handshake with the transmitter
                if (tx_ready) begin
                    tx_valid <= 1'b0;
                    sent     <= 1'b1;
                end
            end else if (!sent) begin
                tx_data  <= word_q[{byte_idx[1:0], 3'b000} +: 8];
                tx_valid <= 1'b1;
            end else if (tx_ready) begin
                // Ready again means the stop bit is out
                if (byte_idx == len_q - 1'b1) begin
                    resp_busy <= 1'b0;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                    sent     <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/mlp_uart_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlp_link_macros.svh"

module mlp_uart_ctrl import mlp_link_pkg::*; #(
    parameter int CLKS_PER_BIT = `MLP_CLKS_PER_BIT
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        uart_rxd,
    input  mlp_state_t mlp_state,
    input  cycle_cnt_t mlp_cycle_cnt,
    input  acc_t       mlp_acc0,
    output logic       uart_txd,
    output logic       wf_push_col0,
    output logic       wf_push_col1,
    output byte_t      wf_data_in,
    output logic       wf_reset,
    output logic       init_act_valid,
    output act_row_t   init_act_data,
    output logic       start_mlp,
    output logic       weights_ready
);

    byte_t     rx_data;
    logic      rx_valid;
    logic      load_weights;
    logic      load_acts;
    logic      exec_req;
    payload_t  payload;
    logic      resp_start;
    payload_t  resp_word;
    resp_len_t resp_len;
    logic      resp_busy;
    byte_t     tx_data;
    logic      tx_valid;
    logic      tx_ready;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_inst (
        .clk(clk), .rst(rst), .rxd(uart_rxd), .rx_data(rx_data), .rx_valid(rx_valid)
    );

    cmd_parser cmd_parser_inst (
        .clk(clk), .rst(rst), .rx_data(rx_data), .rx_valid(rx_valid),
        .mlp_state(mlp_state), .mlp_cycle_cnt(mlp_cycle_cnt), .mlp_acc0(mlp_acc0),
        .resp_busy(resp_busy), .load_weights(load_weights), .load_acts(load_acts),
        .exec_req(exec_req), .payload(payload), .resp_start(resp_start),
        .resp_word(resp_word), .resp_len(resp_len)
    );

    mlp_loader mlp_loader_inst (
        .clk(clk), .rst(rst), .load_weights(load_weights), .load_acts(load_acts),
        .exec_req(exec_req), .payload(payload), .mlp_state(mlp_state),
        .wf_reset(wf_reset), .wf_push_col0(wf_push_col0), .wf_push_col1(wf_push_col1),
        .wf_data_in(wf_data_in), .init_act_valid(init_act_valid),
        .init_act_data(init_act_data), .start_mlp(start_mlp), .weights_ready(weights_ready)
    );

    resp_sender resp_sender_inst (
        .clk(clk), .rst(rst), .resp_start(resp_start), .resp_word(resp_word),
        .resp_len(resp_len), .tx_ready(tx_ready), .resp_busy(resp_busy),
        .tx_data(tx_data), .tx_valid(tx_valid)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_inst (
        .clk(clk), .rst(rst), .tx_data(tx_data), .tx_valid(tx_valid),
        .tx_ready(tx_ready), .txd(uart_txd)
    );

endmodule

`default_nettype wire

// File: testbench/tb_mlp_uart_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlp_link_macros.svh"

module tb_mlp_uart_ctrl import mlp_link_pkg::*; #(
    parameter int CLKS_PER_BIT = `MLP_CLKS_PER_BIT
) ();

    localparam int    N_ROWS      = 8;
    localparam int    HOLD_CYCLES = 20;
    localparam int    GUARD       = 4 * CLKS_PER_BIT;
    // One 8N1 frame is ten bit times of 10 ns cycles
    localparam longint FRAME_NS    = 100 * CLKS_PER_BIT;
    localparam longint WATCHDOG_NS = (N_ROWS * 6 + 10) * FRAME_NS;

    logic       clk;
    logic       rst;
    logic       uart_rxd;
    mlp_state_t mlp_state;
    cycle_cnt_t mlp_cycle_cnt;
    acc_t       mlp_acc0;
    logic       uart_txd;
    logic       wf_push_col0;
    logic       wf_push_col1;
    byte_t      wf_data_in;
    logic       wf_reset;
    logic       init_act_valid;
    act_row_t   init_act_data;
    logic       start_mlp;
    logic       weights_ready;

    // Stimulus and expected values, one entry per row
    string       t_name[N_ROWS];
    logic [7:0]  t_op[N_ROWS];
    logic [31:0] t_pay[N_ROWS];
    logic [3:0]  t_state[N_ROWS];
    logic [4:0]  t_cnt[N_ROWS];
    logic [31:0] t_acc[N_ROWS];
    int          t_exp_push[N_ROWS];
    int          t_exp_act[N_ROWS];
    int          t_exp_reply[N_ROWS];
    logic [31:0] t_exp_word[N_ROWS];
    int          t_exp_start[N_ROWS];
    int          n_fill = 0;

    // Monitor records
    logic [1:0]  push_code[$];
    logic [7:0]  push_data[$];
    logic [15:0] act_data[$];
    logic [7:0]  reply_q[$];
    int          reset_cnt = 0;
    int          reset_pos = 0;
    int          start_cnt = 0;
    int          reply_starts = 0;
    logic        start_prev = 1'b0;
    integer      seed = 35;

    mlp_uart_ctrl #(.CLKS_PER_BIT(CLKS_PER_BIT)) mlp_uart_ctrl_inst (
        .clk(clk), .rst(rst), .uart_rxd(uart_rxd), .mlp_state(mlp_state),
        .mlp_cycle_cnt(mlp_cycle_cnt), .mlp_acc0(mlp_acc0), .uart_txd(uart_txd),
        .wf_push_col0(wf_push_col0), .wf_push_col1(wf_push_col1), .wf_data_in(wf_data_in),
        .wf_reset(wf_reset), .init_act_valid(init_act_valid), .init_act_data(init_act_data),
        .start_mlp(start_mlp), .weights_ready(weights_ready)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %0h actual %0h", name, expected, actual);
            $display("tests failed");
            $fatal;
        end
    endtask

    task automatic add_row(input string name, input logic [7:0] op, input logic [31:0] pay,
                           input logic [3:0] st, input logic [4:0] cnt, input logic [31:0] acc,
                           input int n_push, input int n_act, input int n_reply,
                           input logic [31:0] word, input int start);
        t_name[n_fill]      = name;
        t_op[n_fill]        = op;
        t_pay[n_fill]       = pay;
        t_state[n_fill]     = st;
        t_cnt[n_fill]       = cnt;
        t_acc[n_fill]       = acc;
        t_exp_push[n_fill]  = n_push;
        t_exp_act[n_fill]   = n_act;
        t_exp_reply[n_fill] = n_reply;
        t_exp_word[n_fill]  = word;
        t_exp_start[n_fill] = start;
        n_fill++;
    endtask

    // Host side of the serial link, 8N1 LSB first
    task automatic send_byte(input logic [7:0] b);
        uart_rxd = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (int k = 0; k < 8; k++) begin
            uart_rxd = b[k];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        uart_rxd = 1'b1;
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic run_row(input int i);
        int          push_base;
        int          act_base;
        int          reset_base;
        int          start_base;
        int          reply_base;
        int          starts_base;
        logic [31:0] word;
        push_base   = push_code.size();
        act_base    = act_data.size();
        reset_base  = reset_cnt;
        start_base  = start_cnt;
        reply_base  = reply_q.size();
        starts_base = reply_starts;
        // Execute rows start with the MLP idle
        mlp_state     = (t_exp_start[i] != 0) ? `MLP_STATE_IDLE : t_state[i];
        mlp_cycle_cnt = t_cnt[i];
        mlp_acc0      = t_acc[i];
        send_byte(t_op[i]);
        if (t_op[i] == CMD_WRITE_WEIGHT || t_op[i] == CMD_WRITE_ACT) begin
            for (int k = 0; k < `MLP_PAYLOAD_BYTES; k++) begin
                send_byte(t_pay[i][8*k +: 8]);
            end
        end
        while (push_code.size() - push_base < t_exp_push[i]
               || act_data.size() - act_base < t_exp_act[i]
               || reply_q.size() - reply_base < t_exp_reply[i]
               || start_cnt - start_base < t_exp_start[i]) begin
            @(negedge clk);
        end
        if (t_exp_start[i] != 0) begin
            repeat (HOLD_CYCLES) begin
                @(negedge clk);
                check_value({t_name[i], " start held"}, 1, 32'(start_mlp));
            end
            check_value({t_name[i], " weights ready set"}, 1, 32'(weights_ready));
            // MLP model leaves idle
            mlp_state = t_state[i];
            while (start_mlp) @(negedge clk);
            check_value({t_name[i], " weights ready cleared"}, 0, 32'(weights_ready));
        end
        // Quiet period to catch stray strobes or replies
        repeat (GUARD) @(negedge clk);
        check_value({t_name[i], " fifo reset count"}, (t_exp_push[i] > 0) ? 1 : 0,
                    reset_cnt - reset_base);
        check_value({t_name[i], " push count"}, t_exp_push[i], push_code.size() - push_base);
        for (int k = 0; k < t_exp_push[i]; k++) begin
            // Column 0 then column 1, alternating
            check_value({t_name[i], " push column"}, (k % 2 == 0) ? 1 : 2,
                        32'(push_code[push_base + k]));
            check_value({t_name[i], " push data"}, 32'(t_pay[i][8*k +: 8]),
                        32'(push_data[push_base + k]));
        end
        if (t_exp_push[i] > 0) begin
            // No push may come before the FIFO reset
            check_value({t_name[i], " fifo reset before pushes"}, push_base, reset_pos);
            check_value({t_name[i], " weights ready"}, 1, 32'(weights_ready));
        end
        check_value({t_name[i], " act count"}, t_exp_act[i], act_data.size() - act_base);
        for (int k = 0; k < t_exp_act[i]; k++) begin
            check_value({t_name[i], " act row"}, 32'(t_pay[i][16*k +: 16]),
                        32'(act_data[act_base + k]));
        end
        check_value({t_name[i], " start count"}, t_exp_start[i], start_cnt - start_base);
        check_value({t_name[i], " reply bytes"}, t_exp_reply[i], reply_starts - starts_base);
        word = '0;
        for (int k = 0; k < t_exp_reply[i]; k++) begin
            word[8*k +: 8] = reply_q[reply_base + k];
        end
        check_value({t_name[i], " reply word"}, t_exp_word[i], word);
    endtask

    // Records MLP-side strobes between clock edges
    always @(negedge clk) begin
        if (!rst) begin
            if (wf_reset) begin
                reset_cnt++;
                reset_pos = push_code.size();
            end
            if (wf_push_col0 || wf_push_col1) begin
                push_code.push_back({wf_push_col1, wf_push_col0});
                push_data.push_back(wf_data_in);
            end
            if (init_act_valid) act_data.push_back(init_act_data);
            if (start_mlp && !start_prev) start_cnt++;
            start_prev = start_mlp;
        end
    end

    initial begin : reply_receiver
        logic [7:0] b;
        while (rst !== 1'b0) @(negedge clk);
        forever begin
            @(negedge uart_txd);
            reply_starts++;
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            check_value("reply start bit", 0, 32'(uart_txd));
            for (int k = 0; k < 8; k++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                b[k] = uart_txd;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_value("reply stop bit", 1, 32'(uart_txd));
            reply_q.push_back(b);
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the DUT did not finish the command table in %0d ns", WATCHDOG_NS);
        $display("tests failed");
        $fatal;
    end

    initial begin : main_sequence
        logic [31:0] r;
        logic [3:0]  st;
        logic [4:0]  cnt;
        clk           = 1'b0;
        rst           = 1'b1;
        uart_rxd      = 1'b1;
        mlp_state     = `MLP_STATE_IDLE;
        mlp_cycle_cnt = '0;
        mlp_acc0      = '0;

        r = $random(seed);
        add_row("write_weight", CMD_WRITE_WEIGHT, r, '0, '0, '0, 4, 0, 0, '0, 0);
        r = $random(seed);
        add_row("write_act", CMD_WRITE_ACT, r, '0, '0, '0, 0, 2, 0, '0, 0);
        r   = $random(seed);
        st  = r[3:0];
        cnt = r[8:4];
        // Status byte is the state times 16 plus the cycle count modulo 16
        add_row("status", CMD_STATUS, '0, st, cnt, '0, 0, 0, `MLP_STATUS_BYTES,
                32'(st) * 16 + 32'(cnt) % 16, 0);
        add_row("unknown_opcode", 8'h3c, '0, '0, '0, '0, 0, 0, 0, '0, 0);
        r = $random(seed);
        add_row("read_result", CMD_READ_RESULT, '0, '0, '0, r, 0, 0, `MLP_RESULT_BYTES, r, 0);
        r  = $random(seed);
        st = {r[3:1], 1'b1};
        add_row("execute", CMD_EXECUTE, '0, st, '0, '0, 0, 0, 0, '0, 1);
        r = $random(seed);
        add_row("write_weight_2", CMD_WRITE_WEIGHT, r, '0, '0, '0, 4, 0, 0, '0, 0);
        r   = $random(seed);
        st  = r[7:4];
        cnt = r[12:8];
        add_row("status_2", CMD_STATUS, '0, st, cnt, '0, 0, 0, `MLP_STATUS_BYTES,
                32'(st) * 16 + 32'(cnt) % 16, 0);

        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("reset txd idle", 1, 32'(uart_txd));
        check_value("reset fifo reset", 0, 32'(wf_reset));
        check_value("reset push", 0, 32'({wf_push_col1, wf_push_col0}));
        check_value("reset act valid", 0, 32'(init_act_valid));
        check_value("reset start", 0, 32'(start_mlp));
        check_value("reset weights ready", 0, 32'(weights_ready));

        for (int i = 0; i < N_ROWS; i++) begin
            run_row(i);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
source/mlp_link_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/cmd_parser.sv
source/mlp_loader.sv
source/resp_sender.sv
source/mlp_uart_ctrl.sv
testbench/tb_mlp_uart_ctrl.sv

// File: Makefile
VERILATOR    ?= verilator
TOP          ?= tb_mlp_uart_ctrl
FILELIST     ?= verilog.f
BUILD_DIR    ?= obj_dir
CLKS_PER_BIT ?= 16
JOBS         ?= 0
PASS_MSG     ?= all tests passed
VFLAGS       ?= --timing --top-module $(TOP) -GCLKS_PER_BIT=$(CLKS_PER_BIT)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
